// File: logic/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // serial frame layout.
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;  // start, eight data, parity, stop.

  // command layout.
  localparam int CMD_WRITE_BIT = 15;

  // idle clocks between the two frames of a write.
  localparam int GAP_CYCLES = 100;

  typedef logic [DATA_BITS-1:0] byte_t;

  typedef logic [15:0] cmd_t;  // write flag, 7-bit address, data.

  typedef logic [7:0] gap_cnt_t;

  // clock count within one bit period.
  typedef logic [15:0] bit_cnt_t;

  typedef logic [3:0] bit_idx_t;  // position inside a frame.

  typedef struct packed {
    byte_t data;
    logic  err;  // bad parity or low stop bit.
  } rx_result_t;

endpackage

// File: logic/uart_frame_tx.sv
module uart_frame_tx #(
  parameter int BIT_CLKS = 434
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  uart_cmd_pkg::byte_t data,
  output logic                tx,
  output logic                busy
);
  import uart_cmd_pkg::*;

  logic [DATA_BITS+1:0] frame_q;  // stop, parity and data still to send.
  bit_cnt_t             bit_clk;
  bit_idx_t             bit_idx;
  logic                 bit_end;

  assign bit_end = (bit_clk == bit_cnt_t'(BIT_CLKS - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx      <= 1'b1;
      busy    <= 1'b0;
      bit_clk <= '0;
      bit_idx <= '0;
    end
    else if (!busy)
    begin
      if (start)
      begin
        tx      <= 1'b0;  // start bit.
        busy    <= 1'b1;
        bit_clk <= '0;
        bit_idx <= '0;
      end
    end
    else if (bit_end)
    begin
      bit_clk <= '0;
      if (bit_idx == bit_idx_t'(FRAME_BITS - 1))
      begin
        busy <= 1'b0;  // line is left high by the stop bit.
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= frame_q[0];
      end
    end
    else
    begin
      bit_clk <= bit_clk + 1'b1;
    end
  end

  // odd parity, so the data and parity bits hold an odd count of ones.
  always_ff @(posedge clk)
  begin
    if (start && !busy)
    begin
      frame_q <= {1'b1, ~^data, data};
    end
    else if (busy && bit_end)
    begin
      frame_q <= {1'b1, frame_q[DATA_BITS+1:1]};
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
    else $error("uart_frame_tx: start while a frame is in flight");

endmodule

// File: logic/uart_frame_rx.sv
module uart_frame_rx #(
  parameter int BIT_CLKS = 434
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx,
  output logic                     done,
  output uart_cmd_pkg::rx_result_t result
);
  import uart_cmd_pkg::*;

  logic     rx_s1;
  logic     rx_s2;
  logic     rx_q;
  logic     active;
  bit_cnt_t bit_clk;
  bit_idx_t bit_idx;
  byte_t    shift_q;
  logic     parity_q;
  logic     mid_bit;
  logic     bit_end;

  assign mid_bit = active && (bit_clk == bit_cnt_t'(BIT_CLKS / 2 - 1));
  assign bit_end = (bit_clk == bit_cnt_t'(BIT_CLKS - 1));

  // two-flop synchronizer plus one stage for the edge.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_q  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_q  <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      bit_clk <= '0;
      bit_idx <= '0;
      done    <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (!active)
      begin
        if (rx_q && !rx_s2)
        begin
          active  <= 1'b1;  // falling edge opens a frame.
          bit_clk <= '0;
          bit_idx <= '0;
        end
      end
      else
      begin
        bit_clk <= bit_end ? '0 : bit_clk + 1'b1;
        if (bit_end)
        begin
          bit_idx <= bit_idx + 1'b1;
        end
        if (mid_bit && bit_idx == '0 && rx_s2)
        begin
          active <= 1'b0;  // start bit gone by mid-bit, a glitch.
        end
        else if (mid_bit && bit_idx == bit_idx_t'(FRAME_BITS - 1))
        begin
          active <= 1'b0;  // free again from mid stop bit.
          done   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (mid_bit)
    begin
      if (bit_idx >= bit_idx_t'(1) && bit_idx <= bit_idx_t'(DATA_BITS))
      begin
        shift_q <= {rx_s2, shift_q[DATA_BITS-1:1]};  // lsb arrives first.
      end
      if (bit_idx == bit_idx_t'(DATA_BITS + 1))
      begin
        parity_q <= rx_s2;
      end
      if (bit_idx == bit_idx_t'(FRAME_BITS - 1))
      begin
        result.data <= shift_q;
        result.err  <= ~(^{shift_q, parity_q}) | ~rx_s2;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("uart_frame_rx: done longer than one cycle");

endmodule

// File: logic/uart_cmd_seq.sv
module uart_cmd_seq (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::cmd_t       cmd_in,
  input  logic                     cmd_vld,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output uart_cmd_pkg::byte_t      tx_byte,
  input  logic                     tx_busy,
  input  logic                     rx_done,
  input  uart_cmd_pkg::rx_result_t rx_result,
  output uart_cmd_pkg::byte_t      read_data,
  output logic                     read_err,
  output logic                     read_rdy
);
  import uart_cmd_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HIGH,
    S_GAP,
    S_SEND_LOW,
    S_WAIT_ANSWER
  } state_t;

  state_t   state;
  cmd_t     cmd_q;
  gap_cnt_t gap_cnt;
  logic     accept;
  logic     frame_done;
  logic     gap_done;

  assign cmd_rdy    = (state == S_IDLE);
  assign accept     = cmd_vld && cmd_rdy;
  assign frame_done = !tx_start && !tx_busy;  // busy lags the start pulse by one cycle.
  assign gap_done   = (state == S_GAP) && (gap_cnt == '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      tx_start  <= 1'b0;
      gap_cnt   <= '0;
      read_rdy  <= 1'b0;
      read_data <= '0;
      read_err  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (accept)
          begin
            tx_start <= 1'b1;
            state    <= S_SEND_HIGH;
          end
        end
        S_SEND_HIGH:
        begin
          if (frame_done && cmd_q[CMD_WRITE_BIT])
          begin
            // busy fall and start-to-line delay take the other two gap cycles.
            gap_cnt <= gap_cnt_t'(GAP_CYCLES - 3);
            state   <= S_GAP;
          end
          else if (frame_done)
          begin
            state <= S_WAIT_ANSWER;
          end
        end
        S_GAP:
        begin
          if (gap_done)
          begin
            tx_start <= 1'b1;
            state    <= S_SEND_LOW;
          end
          else
          begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        S_SEND_LOW:
        begin
          if (frame_done)
          begin
            state <= S_IDLE;
          end
        end
        S_WAIT_ANSWER:
        begin
          if (rx_done)
          begin
            read_rdy  <= 1'b1;
            read_data <= rx_result.data;
            read_err  <= rx_result.err;
            state     <= S_IDLE;
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_in;
      tx_byte <= cmd_in[CMD_WRITE_BIT -: DATA_BITS];  // flag and address first.
    end
    else if (gap_done)
    begin
      tx_byte <= cmd_q[DATA_BITS-1:0];
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> $past(state) == S_WAIT_ANSWER && state == S_IDLE)
    else $error("uart_cmd_seq: read_rdy outside an answer");

endmodule

// File: logic/uart_cmd_bridge.sv
module uart_cmd_bridge #(
  parameter int BIT_CLKS = 434
) (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  input  logic                rx,
  output logic                tx,
  output uart_cmd_pkg::byte_t read_data,
  output logic                read_err,
  output logic                read_rdy
);
  import uart_cmd_pkg::*;

  logic       tx_start;
  byte_t      tx_byte;
  logic       tx_busy;
  logic       rx_done;
  rx_result_t rx_result;

  uart_cmd_seq i_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .rx_done   (rx_done),
    .rx_result (rx_result),
    .read_data (read_data),
    .read_err  (read_err),
    .read_rdy  (read_rdy)
  );

  uart_frame_tx #(.BIT_CLKS(BIT_CLKS)) i_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_byte),
    .tx    (tx),
    .busy  (tx_busy)
  );

  // always listening, the sequencer picks the answer it waits for.
  uart_frame_rx #(.BIT_CLKS(BIT_CLKS)) i_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .done   (rx_done),
    .result (rx_result)
  );

endmodule

// File: tests/uart_link_model.sv
module uart_link_model #(
  parameter int BIT_CLKS = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tx,
  output logic                rx,
  input  uart_cmd_pkg::byte_t ans_data,
  input  logic                ans_bad_parity,
  input  int                  ans_delay
);
  timeunit 1ns;
  timeprecision 1ns;
  import uart_cmd_pkg::*;

  logic [9:0] frame_log[$];  // stop, parity and data of each frame.
  int         gap_log[$];    // idle clocks before each frame.
  int         idle_cnt;
  logic       low_next;      // data byte of a write comes next.

  task automatic take_frame();
    logic [9:0] bits;
    repeat (BIT_CLKS / 2 - 1) @(posedge clk);  // to mid start bit.
    for (int i = 0; i < 10; i++)
    begin
      repeat (BIT_CLKS) @(posedge clk);
      bits[i] = tx;
    end
    repeat (BIT_CLKS / 2) @(posedge clk);  // to the end of the stop bit.
    frame_log.push_back(bits);
  endtask

  task automatic send_answer();
    logic [9:0] bits;
    bits = {(~^ans_data) ^ ans_bad_parity, ans_data, 1'b0};
    repeat (ans_delay + 1) @(negedge clk);
    for (int i = 0; i < 10; i++)
    begin
      rx = bits[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
    rx = 1'b1;  // stop bit and idle line.
  endtask

  initial rx = 1'b1;

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      idle_cnt = 0;
      low_next = 1'b0;
    end
    else if (!tx)
    begin
      gap_log.push_back(idle_cnt);
      take_frame();
      idle_cnt = 0;
      if (low_next)
        low_next = 1'b0;
      else if (frame_log[$][7])
        low_next = 1'b1;
      else
        send_answer();
    end
    else
    begin
      idle_cnt++;
    end
  end

endmodule

// File: tests/uart_cmd_bridge_tb.sv
module uart_cmd_bridge_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import uart_cmd_pkg::*;

  localparam int          BIT_CLKS   = 16;
  localparam logic [31:0] SEED       = 32'h74a39859;
  localparam int          WAIT_LIMIT = 1000;

  logic        clk;
  logic        rst_n;
  cmd_t        cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  byte_t       read_data;
  logic        read_err;
  logic        read_rdy;
  byte_t       ans_data;
  logic        ans_bad_parity;
  int          ans_delay;
  logic [31:0] lfsr;
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [9:0]  exp_frames[$];
  logic [8:0]  exp_reads[$];
  logic [8:0]  got_reads[$];

  uart_cmd_bridge #(.BIT_CLKS(BIT_CLKS)) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_err  (read_err),
    .read_rdy  (read_rdy)
  );

  uart_link_model #(.BIT_CLKS(BIT_CLKS)) i_link (
    .clk            (clk),
    .rst_n          (rst_n),
    .tx             (tx),
    .rx             (rx),
    .ans_data       (ans_data),
    .ans_bad_parity (ans_bad_parity),
    .ans_delay      (ans_delay)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (read_rdy)
      got_reads.push_back({read_data, read_err});
  end

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // line image of a byte with high stop, odd parity and data.
  function automatic logic [9:0] frame_of(byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += b[i];
    return {1'b1, ones % 2 == 0, b};
  endfunction

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    assert (expected == actual)
    else
    begin
      $display("FAILED %s expected %0h actual %0h", what, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_ready(logic hold);
    int n;
    n = 0;
    while (!cmd_rdy && n < WAIT_LIMIT)
    begin
      cmd_vld = hold;
      if (hold)
        cmd_in = cmd_t'(rand_bits(16));  // must be ignored while busy.
      @(negedge clk);
      n++;
    end
    cmd_vld = 1'b0;
    if (!cmd_rdy)
    begin
      $display("timeout: cmd_rdy stayed low for %0d cycles", WAIT_LIMIT);
      $display("Test failed");
      $finish;
    end
  endtask

  task automatic run_cmd(cmd_t c, logic bad, logic hold);
    byte_t ans;
    ans = byte_t'(rand_bits(8));
    ans_data = ans;
    ans_bad_parity = bad;
    ans_delay = int'(rand_bits(6));
    exp_frames.push_back(frame_of(c[15:8]));
    if (c[CMD_WRITE_BIT])
      exp_frames.push_back(frame_of(c[7:0]));
    else
      exp_reads.push_back({ans, bad});
    wait_ready(1'b0);
    cmd_in = c;
    cmd_vld = 1'b1;
    @(negedge clk);
    wait_ready(hold);
    @(negedge clk);  // read monitor takes the last pulse.
    if (c[CMD_WRITE_BIT])
    begin
      assert (i_link.gap_log.size() > 0 && i_link.gap_log[$] >= GAP_CYCLES)
      else
      begin
        $display("write frames of command %0h were not separated by the idle gap", c);
        errors++;
      end
    end
  endtask

  task automatic check_logs(string name);
    check_value({name, " frame count"}, exp_frames.size(), i_link.frame_log.size());
    while (exp_frames.size() > 0 && i_link.frame_log.size() > 0)
      check_value({name, " frame"}, exp_frames.pop_front(), i_link.frame_log.pop_front());
    check_value({name, " read count"}, exp_reads.size(), got_reads.size());
    while (exp_reads.size() > 0 && got_reads.size() > 0)
      check_value({name, " read"}, exp_reads.pop_front(), got_reads.pop_front());
    exp_frames.delete();
    exp_reads.delete();
    got_reads.delete();
    i_link.frame_log.delete();
  endtask

  task automatic finish_test(string name, int errs_before);
    tests_run++;
    if (errors == errs_before)
      $display("%s: ok", name);
    else
    begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  initial
  begin
    int   mark;
    cmd_t rand_cmd;
    logic rand_bad;
    lfsr = SEED;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    ans_data = '0;
    ans_bad_parity = 1'b0;
    ans_delay = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    mark = errors;
    check_value("reset", {1'b1, 1'b1, 1'b0, 8'h00, 1'b0},
                {tx, cmd_rdy, read_rdy, read_data, read_err});
    finish_test("reset", mark);

    mark = errors;
    run_cmd(cmd_t'(rand_bits(16)) | 16'h8000, 1'b0, 1'b0);
    check_logs("write");
    finish_test("write", mark);

    mark = errors;
    run_cmd(cmd_t'(rand_bits(16)) & 16'h7fff, 1'b0, 1'b0);
    check_logs("read");
    finish_test("read", mark);

    mark = errors;
    run_cmd(cmd_t'(rand_bits(16)) & 16'h7fff, 1'b1, 1'b0);
    check_logs("bad parity answer");
    finish_test("bad parity answer", mark);

    mark = errors;
    run_cmd(cmd_t'(rand_bits(16)) | 16'h8000, 1'b0, 1'b1);
    run_cmd(cmd_t'(rand_bits(16)) & 16'h7fff, 1'b0, 1'b1);
    check_logs("busy");
    finish_test("busy", mark);

    mark = errors;
    repeat (40)
    begin
      rand_cmd = cmd_t'(rand_bits(16));
      rand_bad = 1'(rand_bits(1));
      run_cmd(rand_cmd, rand_bad, 1'b0);
    end
    check_logs("random traffic");
    finish_test("random traffic", mark);

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: verilog.f
logic/uart_cmd_pkg.sv
logic/uart_frame_tx.sv
logic/uart_frame_rx.sv
logic/uart_cmd_seq.sv
logic/uart_cmd_bridge.sv
tests/uart_link_model.sv
tests/uart_cmd_bridge_tb.sv

// File: Bender.yml
package:
  name: uart_cmd_bridge

sources:
  - logic/uart_cmd_pkg.sv
  - logic/uart_frame_tx.sv
  - logic/uart_frame_rx.sv
  - logic/uart_cmd_seq.sv
  - logic/uart_cmd_bridge.sv
  - target: test
    files:
      - tests/uart_link_model.sv
      - tests/uart_cmd_bridge_tb.sv
